//--- src/ring_config.svh
// sizes shared by RTL and testbench, RING_PTR_W must be able to count 0 to RING_STK_DEPTH
`ifndef RING_CONFIG_SVH
`define RING_CONFIG_SVH
`default_nettype none

`define RING_DATA_W      32 // stack and alu data width
`define RING_STACKS      4  // number of data stacks
`define RING_STK_SEL_W   2  // stack selector width
`define RING_STK_DEPTH   8  // entries per stack
`define RING_PTR_W       4  // pointer counts 0..depth inclusive

// register bus address, taken from the low bits of the immediate
`define RING_RBUS_ADDR_W 8

`default_nettype wire
`endif

//--- src/ring_pkg.sv
// types only, encodings are fixed, no multiply, no pc ops and no memory reads
`default_nettype none

package ring_pkg;

	typedef enum logic [3:0] {
		OP_NOP = 4'h0, // idle slot
		OP_LIT = 4'h1, // immediate onto a
		OP_ADD = 4'h2, // a + b
		OP_SUB = 4'h3, // a - b
		OP_AND = 4'h4,
		OP_OR  = 4'h5,
		OP_XOR = 4'h6,
		OP_SHL = 4'h7, // a << b[4:0]
		OP_POP = 4'h8, // drop top of a
		OP_WR  = 4'h9, // rbus write of a, no pop
		OP_RD  = 4'ha  // rbus read data onto a
	} op_e;

	typedef enum logic [2:0] {
		ALU_PASS_B = 3'd0, // b straight through, used by lit
		ALU_ADD    = 3'd1,
		ALU_SUB    = 3'd2,
		ALU_AND    = 3'd3,
		ALU_OR     = 3'd4,
		ALU_XOR    = 3'd5,
		ALU_SHL    = 3'd6,
		ALU_RBUS   = 3'd7  // take rbus read data at stage two
	} alu_op_e;

endpackage

`default_nettype wire

//--- src/stack_if.sv
// no handshake on any signal, every strobe is a single-cycle pulse on clk_i
`timescale 1ns/1ps
`include "ring_config.svh"
`default_nettype none

interface stack_if;

	logic [`RING_STK_SEL_W-1:0] sel_a; // stack a selector
	logic [`RING_STK_SEL_W-1:0] sel_b; // stack b selector
	logic                       pop_a; // pop a at issue
	logic                       pop_b; // pop b at issue
	logic                       psh; // push from alu stage two
	logic [`RING_STK_SEL_W-1:0] psh_sel; // push target
	logic [`RING_DATA_W-1:0]    psh_data; // push payload
	logic [`RING_DATA_W-1:0]    top_a; // 0 when empty
	logic [`RING_DATA_W-1:0]    top_b;
	logic                       pop_er; // pop on empty, one cycle late
	logic                       psh_er; // push on full, one cycle late

	modport ctrl (output sel_a, sel_b, pop_a, pop_b, input top_a, top_b);
	modport alu (input top_a, top_b, output psh, psh_sel, psh_data);
	modport stk (
		input sel_a, sel_b, pop_a, pop_b, psh, psh_sel, psh_data,
		output top_a, top_b, pop_er, psh_er
	);

endinterface

`default_nettype wire

//--- src/ring_ctrl.sv
// combinational decode at issue, no hazard checks, rbus strobes one cycle after issue
`timescale 1ns/1ps
`include "ring_config.svh"
`default_nettype none

module ring_ctrl (
	input  wire                           clk_i,
	input  wire                           rst_i, // sync, active high
	input  wire                           op_vld_i, // issue strobe
	input  wire ring_pkg::op_e            op_i,
	input  wire [`RING_STK_SEL_W-1:0]     sa_i,
	input  wire [`RING_STK_SEL_W-1:0]     sb_i,
	input  wire                           imda_i, // b from immediate
	input  wire [`RING_DATA_W-1:0]        imm_i,
	stack_if.ctrl                         stk,
	output logic                          alu_go_o, // launch alu stage one
	output ring_pkg::alu_op_e             alu_op_o,
	output logic                          alu_bimm_o,
	output logic [`RING_STK_SEL_W-1:0]    alu_dst_o, // push target for the result
	output logic [`RING_DATA_W-1:0]       alu_imm_o,
	output logic [`RING_RBUS_ADDR_W-1:0]  rbus_addr_o,
	output logic                          rbus_wr_o,
	output logic                          rbus_rd_o,
	output logic [`RING_DATA_W-1:0]       rbus_wr_data_o,
	output logic                          flg_ne_o, // a != b
	output logic                          flg_lt_o // a < b, unsigned
);

	import ring_pkg::*;

	logic is_alu; // two-operand alu op
	logic same_ab; // a and b name one stack
	logic wr_d; // rbus write before the register
	logic rd_d;

	assign stk.sel_a = sa_i;
	assign stk.sel_b = sb_i;
	assign same_ab   = (sa_i == sb_i);
	assign is_alu    = op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL};
	assign alu_dst_o = sa_i; // results always land on a
	assign alu_imm_o = imm_i;

	always_comb begin
		case (op_i)
			OP_ADD:  alu_op_o = ALU_ADD;
			OP_SUB:  alu_op_o = ALU_SUB;
			OP_AND:  alu_op_o = ALU_AND;
			OP_OR:   alu_op_o = ALU_OR;
			OP_XOR:  alu_op_o = ALU_XOR;
			OP_SHL:  alu_op_o = ALU_SHL;
			OP_RD:   alu_op_o = ALU_RBUS;
			default: alu_op_o = ALU_PASS_B; // lit passes the immediate
		endcase
	end

	always_comb begin
		alu_go_o   = op_vld_i && (is_alu || op_i == OP_LIT || op_i == OP_RD);
		alu_bimm_o = imda_i || (op_i == OP_LIT); // lit forces the immediate
		stk.pop_a  = op_vld_i && (is_alu || op_i == OP_POP);
		stk.pop_b  = op_vld_i && is_alu && !imda_i && !same_ab; // one pop if same stack
		wr_d       = op_vld_i && (op_i == OP_WR);
		rd_d       = op_vld_i && (op_i == OP_RD);
	end

	// strobes cleared by reset
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rbus_wr_o <= 1'b0;
			rbus_rd_o <= 1'b0;
		end else begin
			rbus_wr_o <= wr_d;
			rbus_rd_o <= rd_d;
		end
	end

	always_ff @(posedge clk_i) begin
		rbus_addr_o    <= imm_i[`RING_RBUS_ADDR_W-1:0]; // low immediate bits
		rbus_wr_data_o <= stk.top_a; // top a as seen at issue
	end

	assign flg_ne_o = (stk.top_a != stk.top_b);
	assign flg_lt_o = (stk.top_a < stk.top_b);

	// decode must never raise both bus strobes out of one issue
	a_rbus_excl: assert property (@(posedge clk_i) disable iff (rst_i)
		!(rbus_rd_o && rbus_wr_o));

endmodule

`default_nettype wire

//--- src/lifo_stacks.sv
// push on full is dropped, pop on empty is ignored, both flagged one cycle later
`timescale 1ns/1ps
`include "ring_config.svh"
`default_nettype none

module lifo_stacks (
	input  wire   clk_i,
	input  wire   rst_i, // sync, active high
	stack_if.stk  stk
);

	localparam int IDX_W = `RING_PTR_W - 1; // array index width
	localparam logic [`RING_PTR_W-1:0] FULL = `RING_PTR_W'(`RING_STK_DEPTH);

	logic [`RING_DATA_W-1:0] mem [`RING_STACKS][`RING_STK_DEPTH]; // stack storage
	logic [`RING_PTR_W-1:0]  ptr [`RING_STACKS]; // entries held, 0 is empty
	logic [IDX_W-1:0]        top_idx [`RING_STACKS]; // ptr - 1
	logic [IDX_W-1:0]        wr_idx [`RING_STACKS];
	logic [`RING_DATA_W-1:0] top [`RING_STACKS];
	logic [`RING_STACKS-1:0] pop_v; // pop requested
	logic [`RING_STACKS-1:0] pop_ok; // pop with data present
	logic [`RING_STACKS-1:0] psh_v;
	logic [`RING_STACKS-1:0] psh_ok; // push with room or a pop alongside

	always_comb begin
		for (int i = 0; i < `RING_STACKS; i++) begin
			pop_v[i]   = (stk.pop_a && stk.sel_a == `RING_STK_SEL_W'(i)) ||
			             (stk.pop_b && stk.sel_b == `RING_STK_SEL_W'(i));
			pop_ok[i]  = pop_v[i] && (ptr[i] != '0);
			psh_v[i]   = stk.psh && (stk.psh_sel == `RING_STK_SEL_W'(i));
			psh_ok[i]  = psh_v[i] && ((ptr[i] != FULL) || pop_ok[i]); // pop frees a slot
			top_idx[i] = IDX_W'(ptr[i] - 1'b1);
			wr_idx[i]  = pop_ok[i] ? top_idx[i] : IDX_W'(ptr[i]); // overwrite on push+pop
			top[i]     = (ptr[i] == '0) ? '0 : mem[i][top_idx[i]];
		end
	end

	// pointers
	always_ff @(posedge clk_i) begin
		for (int i = 0; i < `RING_STACKS; i++) begin
			if (rst_i) begin
				ptr[i] <= '0;
			end else begin
				case ({pop_ok[i], psh_ok[i]})
					2'b10:   ptr[i] <= ptr[i] - 1'b1;
					2'b01:   ptr[i] <= ptr[i] + 1'b1;
					default: ptr[i] <= ptr[i]; // idle or push+pop
				endcase
			end
		end
	end

	// storage
	always_ff @(posedge clk_i) begin
		for (int i = 0; i < `RING_STACKS; i++) begin
			if (psh_ok[i]) begin
				mem[i][wr_idx[i]] <= stk.psh_data;
			end
		end
	end

	// error pulses
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			stk.pop_er <= 1'b0;
			stk.psh_er <= 1'b0;
		end else begin
			stk.pop_er <= |(pop_v & ~pop_ok); // pop hit an empty stack
			stk.psh_er <= |(psh_v & ~psh_ok); // push hit a full stack
		end
	end

	assign stk.top_a = top[stk.sel_a];
	assign stk.top_b = top[stk.sel_b];

	// push and pop from separate pipeline stages must never overrun a stack
	for (genvar g = 0; g < `RING_STACKS; g++) begin : g_ptr_chk
		a_ptr_range: assert property (@(posedge clk_i) disable iff (rst_i)
			ptr[g] <= FULL);
	end

endmodule

`default_nettype wire

//--- src/ring_alu.sv
// fixed two-stage latency, rbus read data must be valid in the cycle after issue
`timescale 1ns/1ps
`include "ring_config.svh"
`default_nettype none

module ring_alu (
	input  wire                         clk_i,
	input  wire                         rst_i, // sync, active high
	input  wire                         alu_go_i, // launch at issue
	input  wire ring_pkg::alu_op_e      alu_op_i,
	input  wire                         alu_bimm_i, // b from immediate
	input  wire [`RING_STK_SEL_W-1:0]   alu_dst_i,
	input  wire [`RING_DATA_W-1:0]      alu_imm_i,
	input  wire [`RING_DATA_W-1:0]      rbus_rd_data_i,
	stack_if.alu                        stk
);

	import ring_pkg::*;

	localparam int SH_W = $clog2(`RING_DATA_W); // shift amount bits

	logic                       s1_vld;
	alu_op_e                    s1_op;
	logic [`RING_DATA_W-1:0]    s1_a;
	logic [`RING_DATA_W-1:0]    s1_b;
	logic [`RING_STK_SEL_W-1:0] s1_dst;
	logic [`RING_DATA_W-1:0]    res; // stage two result before the register
	logic                       s2_vld;
	logic [`RING_STK_SEL_W-1:0] s2_dst;
	logic [`RING_DATA_W-1:0]    s2_res;

	// valid chain
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			s1_vld <= 1'b0;
			s2_vld <= 1'b0;
		end else begin
			s1_vld <= alu_go_i;
			s2_vld <= s1_vld;
		end
	end

	// stage one, operands as seen at issue
	always_ff @(posedge clk_i) begin
		s1_op  <= alu_op_i;
		s1_a   <= stk.top_a;
		s1_b   <= alu_bimm_i ? alu_imm_i : stk.top_b;
		s1_dst <= alu_dst_i;
	end

	always_comb begin
		case (s1_op)
			ALU_ADD:  res = s1_a + s1_b;
			ALU_SUB:  res = s1_a - s1_b; // a minus b
			ALU_AND:  res = s1_a & s1_b;
			ALU_OR:   res = s1_a | s1_b;
			ALU_XOR:  res = s1_a ^ s1_b;
			ALU_SHL:  res = s1_a << s1_b[SH_W-1:0];
			ALU_RBUS: res = rbus_rd_data_i; // slave answers during this cycle
			default:  res = s1_b; // pass b
		endcase
	end

	// stage two
	always_ff @(posedge clk_i) begin
		s2_res <= res;
		s2_dst <= s1_dst;
	end

	assign stk.psh      = s2_vld;
	assign stk.psh_sel  = s2_dst;
	assign stk.psh_data = s2_res;

	// the push strobe feeds stack pointers, so it must be clean once reset drops
	a_psh_known: assert property (@(posedge clk_i) disable iff (rst_i)
		!$isunknown(stk.psh));

endmodule

`default_nettype wire

//--- src/data_ring_top.sv
// data path only, no pc, fetch or threads, hazards on in-flight pushes left to the issuer
`timescale 1ns/1ps
`include "ring_config.svh"
`default_nettype none

module data_ring_top (
	input  wire                           clk_i,
	input  wire                           rst_i, // sync, active high
	input  wire                           op_vld_i,
	input  wire ring_pkg::op_e            op_i,
	input  wire [`RING_STK_SEL_W-1:0]     sa_i,
	input  wire [`RING_STK_SEL_W-1:0]     sb_i,
	input  wire                           imda_i,
	input  wire [`RING_DATA_W-1:0]        imm_i,
	input  wire [`RING_DATA_W-1:0]        rbus_rd_data_i,
	output logic [`RING_DATA_W-1:0]       a_o, // top of stack a
	output logic [`RING_DATA_W-1:0]       b_o,
	output logic                          flg_ne_o,
	output logic                          flg_lt_o,
	output logic [`RING_RBUS_ADDR_W-1:0]  rbus_addr_o,
	output logic                          rbus_wr_o,
	output logic                          rbus_rd_o,
	output logic [`RING_DATA_W-1:0]       rbus_wr_data_o,
	output logic                          pop_er_o,
	output logic                          psh_er_o
);

	import ring_pkg::*;

	logic                       alu_go;
	alu_op_e                    alu_op;
	logic                       alu_bimm;
	logic [`RING_STK_SEL_W-1:0] alu_dst;
	logic [`RING_DATA_W-1:0]    alu_imm;

	stack_if stk_bus ();

	ring_ctrl u_ctrl (
		.clk_i, .rst_i, .op_vld_i, .op_i, .sa_i, .sb_i, .imda_i, .imm_i,
		.stk            (stk_bus.ctrl),
		.alu_go_o       (alu_go),
		.alu_op_o       (alu_op),
		.alu_bimm_o     (alu_bimm),
		.alu_dst_o      (alu_dst),
		.alu_imm_o      (alu_imm),
		.rbus_addr_o, .rbus_wr_o, .rbus_rd_o, .rbus_wr_data_o,
		.flg_ne_o, .flg_lt_o
	);

	lifo_stacks u_stacks (
		.clk_i, .rst_i,
		.stk (stk_bus.stk)
	);

	ring_alu u_alu (
		.clk_i, .rst_i,
		.alu_go_i       (alu_go),
		.alu_op_i       (alu_op),
		.alu_bimm_i     (alu_bimm),
		.alu_dst_i      (alu_dst),
		.alu_imm_i      (alu_imm),
		.rbus_rd_data_i,
		.stk            (stk_bus.alu)
	);

	assign a_o      = stk_bus.top_a;
	assign b_o      = stk_bus.top_b;
	assign pop_er_o = stk_bus.pop_er;
	assign psh_er_o = stk_bus.psh_er;

endmodule

`default_nettype wire

//--- sim/tb_data_ring.sv
// single clock, ops issued only by the stimulus table, rbus slave answers addr ^ 5a5a0000
`timescale 1ns/1ps
`include "ring_config.svh"
`default_nettype none

module tb_data_ring;

	import ring_pkg::*;

	typedef struct packed {
		op_e                     op;
		int                      sa;
		int                      sb;
		logic                    imda;
		logic [`RING_DATA_W-1:0] imm;
		logic                    rnd; // immediate taken from the lfsr
		int                      idle; // idle cycles after the op
		int                      test;
	} row_t;

	logic                          clk_i;
	logic                          rst_i;
	logic                          op_vld_i;
	op_e                           op_i;
	logic [`RING_STK_SEL_W-1:0]    sa_i;
	logic [`RING_STK_SEL_W-1:0]    sb_i;
	logic                          imda_i;
	logic [`RING_DATA_W-1:0]       imm_i;
	logic [`RING_DATA_W-1:0]       rbus_rd_data_i;
	logic [`RING_DATA_W-1:0]       a_o;
	logic [`RING_DATA_W-1:0]       b_o;
	logic                          flg_ne_o;
	logic                          flg_lt_o;
	logic [`RING_RBUS_ADDR_W-1:0]  rbus_addr_o;
	logic                          rbus_wr_o;
	logic                          rbus_rd_o;
	logic [`RING_DATA_W-1:0]       rbus_wr_data_o;
	logic                          pop_er_o;
	logic                          psh_er_o;

	logic [`RING_DATA_W-1:0] m_mem [`RING_STACKS][`RING_STK_DEPTH]; // stack model
	int                      m_ptr [`RING_STACKS];
	logic                    d1_vld; // push issued one edge ago
	int                      d1_dst;
	logic [`RING_DATA_W-1:0] d1_data;
	logic                    d2_vld; // push due at this edge
	int                      d2_dst;
	logic [`RING_DATA_W-1:0] d2_data;
	logic                    e_pop_er; // expected outputs for the current cycle
	logic                    e_psh_er;
	logic                    e_wr;
	logic                    e_rd;
	logic [`RING_RBUS_ADDR_W-1:0] e_addr;
	logic [`RING_DATA_W-1:0] e_wdata;
	logic [`RING_DATA_W-1:0] wr_log [$]; // every write seen on the rbus
	logic [`RING_DATA_W-1:0] exp_wr [$]; // write data the slave should record
	row_t                    tbl [$];
	logic [31:0]             lfsr_q;
	int                      errs;
	int                      checks;
	int                      t_errs;
	int                      t_checks;
	int                      tests_run;
	int                      cyc;
	int                      cyc_limit;

	data_ring_top dut (.*);

	always #5 clk_i = ~clk_i;

	// slave read data, zero outside a read
	assign rbus_rd_data_i = (rbus_rd_o === 1'b1) ?
		({{(`RING_DATA_W-`RING_RBUS_ADDR_W){1'b0}}, rbus_addr_o} ^ 32'h5a5a0000) : '0;

	always @(posedge clk_i) begin
		if (rbus_wr_o === 1'b1) wr_log.push_back(rbus_wr_data_o);
	end

	always @(posedge clk_i) begin
		cyc++;
		if (cyc_limit != 0 && cyc > cyc_limit) begin
			$display("timeout, run stopped after %0d cycles", cyc);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // galois, taps 32 22 2 1
	endfunction

	task automatic next_rand(output logic [`RING_DATA_W-1:0] r);
		r = '0;
		for (int i = 0; i < `RING_DATA_W; i++) begin
			r      = {r[`RING_DATA_W-2:0], lfsr_q[0]}; // one step per bit
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	function automatic logic [`RING_DATA_W-1:0] mtop(input int s);
		if (m_ptr[s] == 0) return '0; // empty stack reads 0
		return m_mem[s][m_ptr[s]-1];
	endfunction

	task automatic model_pop(input int s);
		if (m_ptr[s] == 0) e_pop_er = 1'b1; // pointer stays
		else m_ptr[s]--;
	endtask

	task automatic model_push(input int s, input logic [`RING_DATA_W-1:0] d);
		if (m_ptr[s] == `RING_STK_DEPTH) begin
			e_psh_er = 1'b1; // dropped
		end else begin
			m_mem[s][m_ptr[s]] = d;
			m_ptr[s]++;
		end
	endtask

	// one clock edge of the model, using the inputs the dut samples there
	task automatic model_edge();
		int                      sa;
		int                      sb;
		logic [`RING_DATA_W-1:0] a;
		logic [`RING_DATA_W-1:0] b;
		logic [`RING_DATA_W-1:0] res;
		logic                    go;
		logic                    two_op;
		sa       = int'(sa_i);
		sb       = int'(sb_i);
		a        = mtop(sa); // operands before any pop or push
		b        = imda_i ? imm_i : mtop(sb);
		res      = '0;
		go       = 1'b0;
		two_op   = 1'b0;
		e_pop_er = 1'b0;
		e_psh_er = 1'b0;
		e_wr     = 1'b0;
		e_rd     = 1'b0;
		if (op_vld_i) begin
			two_op = op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL};
			go     = two_op || op_i == OP_LIT || op_i == OP_RD;
			case (op_i)
				OP_LIT:  res = imm_i;
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_XOR:  res = a ^ b;
				OP_SHL:  res = a << b[4:0];
				OP_RD:   res = {{(`RING_DATA_W-`RING_RBUS_ADDR_W){1'b0}},
					imm_i[`RING_RBUS_ADDR_W-1:0]} ^ 32'h5a5a0000; // slave answer
				default: res = '0;
			endcase
			if (two_op) model_pop(sa);
			if (two_op && !imda_i && sb != sa) model_pop(sb); // same stack pops once
			if (op_i == OP_POP) model_pop(sa);
			e_wr    = (op_i == OP_WR);
			e_rd    = (op_i == OP_RD);
			e_addr  = imm_i[`RING_RBUS_ADDR_W-1:0];
			e_wdata = a;
			if (e_wr) exp_wr.push_back(a);
		end
		if (d2_vld) model_push(d2_dst, d2_data); // lands two edges after issue
		d2_vld  = d1_vld;
		d2_dst  = d1_dst;
		d2_data = d1_data;
		d1_vld  = go;
		d1_dst  = sa;
		d1_data = res;
	endtask

	task automatic check_word(input string name, input logic [`RING_DATA_W-1:0] got,
			input logic [`RING_DATA_W-1:0] exp);
		checks++;
		t_checks++;
		assert (got === exp) else begin
			$display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
			errs++;
			t_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		t_checks++;
		assert (got === exp) else begin
			$display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
			errs++;
			t_errs++;
		end
	endtask

	task automatic check_outputs();
		logic [`RING_DATA_W-1:0] ta;
		logic [`RING_DATA_W-1:0] tb;
		ta = mtop(int'(sa_i));
		tb = mtop(int'(sb_i));
		check_word("a_o", a_o, ta);
		check_word("b_o", b_o, tb);
		check_bit("flg_ne_o", flg_ne_o, ta != tb);
		check_bit("flg_lt_o", flg_lt_o, ta < tb); // unsigned compare
		check_bit("pop_er_o", pop_er_o, e_pop_er);
		check_bit("psh_er_o", psh_er_o, e_psh_er);
		check_bit("rbus_wr_o", rbus_wr_o, e_wr);
		check_bit("rbus_rd_o", rbus_rd_o, e_rd);
		if (e_wr) check_word("rbus_wr_data_o", rbus_wr_data_o, e_wdata);
		if (e_wr || e_rd) check_word("rbus_addr_o", 32'(rbus_addr_o), 32'(e_addr));
	endtask

	task automatic step(input logic vld, input op_e op, input int sa, input int sb,
			input logic imda, input logic [`RING_DATA_W-1:0] imm);
		@(posedge clk_i);
		model_edge(); // dut samples the same inputs here
		op_vld_i <= vld;
		op_i     <= op;
		sa_i     <= `RING_STK_SEL_W'(sa);
		sb_i     <= `RING_STK_SEL_W'(sb);
		imda_i   <= imda;
		imm_i    <= imm;
		@(negedge clk_i);
		check_outputs(); // mid cycle, everything settled
	endtask

	task automatic add_row(input op_e op, input int sa, input int sb, input logic imda,
			input logic [`RING_DATA_W-1:0] imm, input logic rnd, input int idle, input int test);
		tbl.push_back(row_t'{op, sa, sb, imda, imm, rnd, idle, test});
	endtask

	task automatic report_test(input int n);
		$display("test %0d: %0d checks, %0d errors", n, t_checks, t_errs);
		tests_run++;
		t_checks = 0;
		t_errs   = 0;
	endtask

	initial begin
		op_e                     alu_ops [6];
		logic [`RING_DATA_W-1:0] imm;
		int                      cur_test;
		clk_i     = 1'b0;
		rst_i     = 1'b1;
		op_vld_i  = 1'b0;
		op_i      = OP_NOP;
		sa_i      = '0;
		sb_i      = '0;
		imda_i    = 1'b0;
		imm_i     = '0;
		lfsr_q    = 32'ha5de0f4a;
		d1_vld    = 1'b0;
		d2_vld    = 1'b0;
		m_ptr     = '{default: 0};
		alu_ops   = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL};
		// lifo order on stack 0
		add_row(OP_LIT, 0, 1, 1'b0, 32'h11, 1'b0, 0, 1);
		add_row(OP_LIT, 0, 1, 1'b0, 32'h22, 1'b0, 0, 1);
		add_row(OP_LIT, 0, 1, 1'b0, 32'h33, 1'b0, 2, 1);
		add_row(OP_POP, 0, 1, 1'b0, 32'h0, 1'b0, 1, 1);
		add_row(OP_POP, 0, 1, 1'b0, 32'h0, 1'b0, 1, 1);
		add_row(OP_POP, 0, 1, 1'b0, 32'h0, 1'b0, 1, 1);
		foreach (alu_ops[i]) begin
			add_row(OP_LIT, 1, 2, 1'b0, 32'h0, 1'b1, 0, 2);
			add_row(OP_LIT, 2, 1, 1'b0, 32'h0, 1'b1, 2, 2);
			add_row(alu_ops[i], 1, 2, 1'b0, 32'h0, 1'b0, 2, 2); // a on 1, b on 2
		end
		add_row(OP_LIT, 0, 1, 1'b0, 32'h0, 1'b1, 2, 3);
		add_row(OP_ADD, 0, 1, 1'b1, 32'h0, 1'b1, 2, 3); // stack 1 untouched
		add_row(OP_LIT, 0, 1, 1'b0, 32'h0, 1'b1, 2, 3);
		add_row(OP_SUB, 0, 0, 1'b0, 32'h0, 1'b0, 2, 3); // single pop, a - a
		add_row(OP_WR, 0, 1, 1'b0, 32'h1234563c, 1'b0, 1, 4);
		add_row(OP_RD, 2, 0, 1'b0, 32'h000000a7, 1'b0, 2, 4);
		add_row(OP_WR, 2, 0, 1'b0, 32'h00000055, 1'b0, 2, 4); // writes the read value
		add_row(OP_POP, 0, 3, 1'b0, 32'h0, 1'b0, 0, 5); // empty stack 0 before filling it
		add_row(OP_POP, 0, 3, 1'b0, 32'h0, 1'b0, 0, 5);
		for (int i = 0; i < `RING_STK_DEPTH + 1; i++) begin
			add_row(OP_LIT, 0, 3, 1'b0, 32'h0, 1'b1, (i == `RING_STK_DEPTH) ? 2 : 0, 5);
		end
		add_row(OP_POP, 3, 0, 1'b0, 32'h0, 1'b0, 1, 5); // stack 3 still empty
		add_row(OP_POP, 3, 0, 1'b0, 32'h0, 1'b0, 1, 5);
		add_row(OP_LIT, 2, 3, 1'b0, 32'h0, 1'b1, 0, 6);
		add_row(OP_LIT, 3, 2, 1'b0, 32'h0, 1'b1, 2, 6);
		add_row(OP_ADD, 2, 3, 1'b1, 32'h0, 1'b1, 0, 6);
		add_row(OP_XOR, 3, 2, 1'b1, 32'h0, 1'b1, 3, 6); // both pushes in flight
		foreach (tbl[i]) cyc_limit += 1 + tbl[i].idle;
		cyc_limit += 50;
		repeat (3) @(posedge clk_i);
		rst_i <= 1'b0;
		step(1'b0, OP_NOP, 0, 1, 1'b0, '0); // reset values
		cur_test = tbl[0].test;
		foreach (tbl[i]) begin
			if (tbl[i].test != cur_test) begin
				report_test(cur_test);
				cur_test = tbl[i].test;
			end
			imm = tbl[i].imm;
			if (tbl[i].rnd) next_rand(imm);
			step(1'b1, tbl[i].op, tbl[i].sa, tbl[i].sb, tbl[i].imda, imm);
			repeat (tbl[i].idle) step(1'b0, OP_NOP, tbl[i].sa, tbl[i].sb, 1'b0, '0);
		end
		checks++;
		assert (wr_log.size() == exp_wr.size()) else begin
			$display("rbus slave saw %0d writes where %0d were issued", wr_log.size(),
				exp_wr.size());
			errs++;
		end
		foreach (exp_wr[i]) begin
			if (i < wr_log.size()) check_word("wr_log", wr_log[i], exp_wr[i]);
		end
		report_test(cur_test);
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errs);
		if (errs == 0) $display("Verification passed");
		else $display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/ring_pkg.sv
src/stack_if.sv
src/ring_ctrl.sv
src/lifo_stacks.sv
src/ring_alu.sv
src/data_ring_top.sv
sim/tb_data_ring.sv

//--- Makefile
# Verilator flow for the data ring, sim passes only when the pass message is printed
TOP := tb_data_ring

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -sv -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -sv -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
